// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    input  rv_pkg::alu_op_t op,
    output logic [31:0]     result,
    output logic            zero
);
    logic               mul_signed;
    logic [32:0]        a_ext;
    logic [32:0]        b_ext;
    logic signed [63:0] product;
    logic [31:0]        quotient;
    logic [31:0]        remainder;

    // one 33x33 multiplier serves mul, mulh and mulhu.
    assign mul_signed = (op == rv_pkg::ALU_MULH);
    assign a_ext      = {mul_signed & a[31], a};
    assign b_ext      = {mul_signed & b[31], b};
    assign product    = $signed(a_ext) * $signed(b_ext);

    assign quotient  = (b == 32'h0) ? 32'hffff_ffff : a / b;
    assign remainder = (b == 32'h0) ? a : a % b;

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD:   result = a + b;
            rv_pkg::ALU_SUB:   result = a - b;
            rv_pkg::ALU_AND:   result = a & b;
            rv_pkg::ALU_OR:    result = a | b;
            rv_pkg::ALU_XOR:   result = a ^ b;
            rv_pkg::ALU_SLL:   result = a << b[4:0];
            rv_pkg::ALU_SRL:   result = a >> b[4:0];
            rv_pkg::ALU_SRA:   result = $signed(a) >>> b[4:0];
            rv_pkg::ALU_SLT:   result = {31'h0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU:  result = {31'h0, a < b};
            rv_pkg::ALU_MUL:   result = product[31:0];
            rv_pkg::ALU_MULH:  result = product[63:32];
            rv_pkg::ALU_MULHU: result = product[63:32];
            rv_pkg::ALU_DIVU:  result = quotient;
            rv_pkg::ALU_REMU:  result = remainder;
            default:           result = b; // lui.
        endcase
    end

    assign zero = (result == 32'h0);

endmodule

`default_nettype wire

// ==== control.sv ====
`timescale 1ns/1ps
`default_nettype none

module control (
    input  rv_pkg::rv_instr_t instr,
    output rv_pkg::alu_op_t   alu_op,
    output logic              alu_src_imm,
    output logic              alu_src_pc,
    output logic              branch,
    output logic              branch_unsigned,
    output logic              branch_invert,
    output logic              jal,
    output logic              jalr,
    output logic              mem_read,
    output logic              mem_write,
    output logic [1:0]        mem_size,
    output logic              load_unsigned,
    output logic              reg_write,
    output rv_pkg::wb_sel_t   wb_sel,
    output logic [1:0]        csr_op,
    output logic              ecall,
    output logic              ebreak,
    output logic              mret
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_r;
    logic       is_imm;
    logic       is_lui;
    logic       is_auipc;
    logic       is_csr;

    assign opcode = instr.r_fmt.opcode;
    assign funct3 = instr.r_fmt.funct3;
    assign funct7 = instr.r_fmt.funct7; // imm[11:5] for shift immediates.

    assign is_r     = (opcode == rv_pkg::OP_R);
    assign is_imm   = (opcode == rv_pkg::OP_IMM);
    assign is_lui   = (opcode == rv_pkg::OP_LUI);
    assign is_auipc = (opcode == rv_pkg::OP_AUIPC);
    assign is_csr   = (opcode == rv_pkg::OP_SYSTEM) && (funct3[1:0] != 2'b00) && !funct3[2];

    assign jal       = (opcode == rv_pkg::OP_JAL);
    assign jalr      = (opcode == rv_pkg::OP_JALR);
    assign branch    = (opcode == rv_pkg::OP_BRANCH);
    assign mem_read  = (opcode == rv_pkg::OP_LOAD);
    assign mem_write = (opcode == rv_pkg::OP_STORE);

    assign branch_unsigned = branch && funct3[1];
    assign branch_invert   = branch && (funct3[0] ^ funct3[2]); // bne, blt, bltu want zero low.

    assign mem_size      = funct3[1:0];
    assign load_unsigned = funct3[2];

    assign alu_src_imm = !(is_r || branch);
    assign alu_src_pc  = is_auipc;
    assign reg_write   = is_r || is_imm || mem_read || is_lui || is_auipc || jal || jalr || is_csr;
    assign csr_op      = is_csr ? funct3[1:0] : 2'b00;

    assign ecall  = (instr == rv_pkg::INSTR_ECALL);
    assign ebreak = (instr == rv_pkg::INSTR_EBREAK);
    assign mret   = (instr == rv_pkg::INSTR_MRET);

    always_comb begin
        if (mem_read) begin
            wb_sel = rv_pkg::WB_MEM;
        end else if (jal || jalr) begin
            wb_sel = rv_pkg::WB_PC4;
        end else if (is_csr) begin
            wb_sel = rv_pkg::WB_CSR;
        end else begin
            wb_sel = rv_pkg::WB_ALU;
        end
    end

    always_comb begin
        alu_op = rv_pkg::ALU_ADD; // loads, stores, auipc, jalr.
        if (is_r && funct7 == rv_pkg::F7_MULDIV) begin
            case (funct3)
                3'b000:  alu_op = rv_pkg::ALU_MUL;
                3'b001:  alu_op = rv_pkg::ALU_MULH;
                3'b011:  alu_op = rv_pkg::ALU_MULHU;
                3'b101:  alu_op = rv_pkg::ALU_DIVU;
                3'b111:  alu_op = rv_pkg::ALU_REMU;
                default: alu_op = rv_pkg::ALU_ADD;
            endcase
        end else if (is_r || is_imm) begin
            case (funct3)
                3'b000:  alu_op = (is_r && funct7[5]) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                3'b001:  alu_op = rv_pkg::ALU_SLL;
                3'b010:  alu_op = rv_pkg::ALU_SLT;
                3'b011:  alu_op = rv_pkg::ALU_SLTU;
                3'b100:  alu_op = rv_pkg::ALU_XOR;
                3'b101:  alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'b110:  alu_op = rv_pkg::ALU_OR;
                default: alu_op = rv_pkg::ALU_AND;
            endcase
        end else if (branch) begin
            if (!funct3[2]) begin
                alu_op = rv_pkg::ALU_SUB; // beq and bne.
            end else begin
                alu_op = branch_unsigned ? rv_pkg::ALU_SLTU : rv_pkg::ALU_SLT;
            end
        end else if (is_lui) begin
            alu_op = rv_pkg::ALU_PASS_B;
        end
    end

    always_comb begin
        assert (!(mem_read && mem_write))
            else $error("control: load and store decoded together.");
    end

endmodule

`default_nettype wire

// ==== core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top #(
    parameter logic [31:0] RESET_PC    = 32'h0000_0000,
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_rdata,
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    output logic [3:0]  dmem_wstrb,
    output logic        dmem_re,
    input  logic [31:0] dmem_rdata
);
    rv_pkg::rv_instr_t instr;
    rv_pkg::alu_op_t   alu_op;
    rv_pkg::wb_sel_t   wb_sel;
    logic              alu_src_imm, alu_src_pc, branch, branch_unsigned, branch_invert;
    logic              jal, jalr, mem_read, mem_write, load_unsigned, reg_write;
    logic              ecall, ebreak, mret, zero, taken;
    logic [1:0]        mem_size, csr_op, byte_off;
    logic [3:0]        store_strb;
    logic [31:0]       pc, pc_next, pc_plus4, target, imm;
    logic [31:0]       rs1_data, rs2_data, alu_a, alu_b, alu_result;
    logic [31:0]       csr_rdata, trap_target, ret_target;
    logic [31:0]       load_shifted, load_data, wb_data;

    assign instr     = imem_rdata;
    assign imem_addr = pc;
    assign pc_plus4  = pc + 32'd4;
    assign target    = pc + imm; // branch and jal target.

    control u_control (.*);
    imm_gen u_imm_gen (.*);

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (instr.r_fmt.rs1),
        .rs2_addr (instr.r_fmt.rs2),
        .rd_addr  (instr.r_fmt.rd),
        .we       (reg_write),
        .rd_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign alu_a = alu_src_pc ? pc : rs1_data;
    assign alu_b = alu_src_imm ? imm : rs2_data;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (zero)
    );

    csr_unit #(.MTVEC_RESET(MTVEC_RESET)) u_csr_unit (
        .clk         (clk),
        .reset       (reset),
        .csr_addr    (instr.i_fmt.imm),
        .csr_op      (csr_op),
        .csr_wdata   (rs1_data),
        .pc          (pc),
        .ecall       (ecall),
        .ebreak      (ebreak),
        .mret        (mret),
        .csr_rdata   (csr_rdata),
        .trap_target (trap_target),
        .ret_target  (ret_target)
    );

    assign taken = branch && (zero ^ branch_invert);

    always_comb begin
        if (ecall || ebreak) begin
            pc_next = trap_target;
        end else if (mret) begin
            pc_next = ret_target;
        end else if (jalr) begin
            pc_next = {alu_result[31:1], 1'b0};
        end else if (jal || taken) begin
            pc_next = target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign dmem_addr  = alu_result;
    assign byte_off   = alu_result[1:0];
    assign dmem_wdata = rs2_data << {byte_off, 3'b000}; // move data to its lanes.

    always_comb begin
        case (mem_size)
            2'b00:   store_strb = 4'b0001 << byte_off;
            2'b01:   store_strb = 4'b0011 << byte_off;
            default: store_strb = 4'b1111;
        endcase
    end

    assign dmem_wstrb = (mem_write && !reset) ? store_strb : 4'b0000;
    assign dmem_re    = mem_read && !reset;

    assign load_shifted = dmem_rdata >> {byte_off, 3'b000};

    always_comb begin
        case (mem_size)
            2'b00:   load_data = {{24{~load_unsigned & load_shifted[7]}}, load_shifted[7:0]};
            2'b01:   load_data = {{16{~load_unsigned & load_shifted[15]}}, load_shifted[15:0]};
            default: load_data = dmem_rdata;
        endcase
    end

    always_comb begin
        case (wb_sel)
            rv_pkg::WB_MEM: wb_data = load_data;
            rv_pkg::WB_PC4: wb_data = pc_plus4;
            rv_pkg::WB_CSR: wb_data = csr_rdata;
            default:        wb_data = alu_result;
        endcase
    end

    pc_word_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_addr[1:0] == 2'b00)
        else $error("core_top: fetch address not word aligned.");

    // taken is formed here, so the compare that control picks must be the unsigned one.
    unsigned_branch_sltu: assert property (@(posedge clk) disable iff (reset)
        (branch && branch_unsigned) |-> (alu_op == rv_pkg::ALU_SLTU))
        else $error("core_top: unsigned branch without sltu.");

endmodule

`default_nettype wire

// ==== csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [11:0] csr_addr,
    input  logic [1:0]  csr_op,
    input  logic [31:0] csr_wdata,
    input  logic [31:0] pc,
    input  logic        ecall,
    input  logic        ebreak,
    input  logic        mret,
    output logic [31:0] csr_rdata,
    output logic [31:0] trap_target,
    output logic [31:0] ret_target
);
    localparam int MIE  = 3;
    localparam int MPIE = 7;
    localparam logic [31:0] MSTATUS_MASK = (32'h1 << MIE) | (32'h1 << MPIE);

    logic [31:0] mstatus;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] wr_value;

    always_comb begin
        case (csr_addr)
            rv_pkg::CSR_MSTATUS: csr_rdata = mstatus;
            rv_pkg::CSR_MTVEC:   csr_rdata = mtvec;
            rv_pkg::CSR_MEPC:    csr_rdata = mepc;
            rv_pkg::CSR_MCAUSE:  csr_rdata = mcause;
            default:             csr_rdata = 32'h0;
        endcase
    end

    always_comb begin
        case (csr_op)
            2'b01:   wr_value = csr_wdata; // csrrw.
            2'b10:   wr_value = csr_rdata | csr_wdata;
            2'b11:   wr_value = csr_rdata & ~csr_wdata;
            default: wr_value = csr_rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus <= 32'h0;
            mtvec   <= MTVEC_RESET;
            mepc    <= 32'h0;
            mcause  <= 32'h0;
        end else if (ecall || ebreak) begin
            mepc          <= pc;
            mcause        <= ecall ? rv_pkg::CAUSE_ECALL : rv_pkg::CAUSE_EBREAK;
            mstatus[MPIE] <= mstatus[MIE];
            mstatus[MIE]  <= 1'b0;
        end else if (mret) begin
            mstatus[MIE]  <= mstatus[MPIE];
            mstatus[MPIE] <= 1'b1;
        end else if (csr_op != 2'b00) begin
            case (csr_addr)
                rv_pkg::CSR_MSTATUS: mstatus <= wr_value & MSTATUS_MASK;
                rv_pkg::CSR_MTVEC:   mtvec   <= wr_value;
                rv_pkg::CSR_MEPC:    mepc    <= wr_value;
                rv_pkg::CSR_MCAUSE:  mcause  <= wr_value;
                default:             mcause  <= mcause; // unknown address, no effect.
            endcase
        end
    end

    assign trap_target = mtvec;
    assign ret_target  = mepc;

    ecall_not_with_mret: assert property (@(posedge clk) disable iff (reset)
        !(ecall && mret))
        else $error("csr_unit: trap entry and return in one cycle.");

endmodule

`default_nettype wire

// ==== imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  rv_pkg::rv_instr_t instr,
    output logic [31:0]       imm
);

    always_comb begin
        case (instr.r_fmt.opcode)
            rv_pkg::OP_IMM, rv_pkg::OP_LOAD, rv_pkg::OP_JALR, rv_pkg::OP_SYSTEM: begin
                imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            rv_pkg::OP_STORE: begin
                imm = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                       instr.s_fmt.imm_4_0};
            end
            rv_pkg::OP_BRANCH: begin
                imm = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                       instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
            end
            rv_pkg::OP_LUI, rv_pkg::OP_AUIPC: begin
                imm = {instr.u_fmt.imm_31_12, 12'h000};
            end
            rv_pkg::OP_JAL: begin
                imm = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                       instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
            end
            default: begin
                imm = 32'h0; // r-type has no immediate.
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic [4:0]  rd_addr,
    input  logic        we,
    input  logic [31:0] rd_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (we && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // x0 stays zero only because reset clears it and writes skip it.
    x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
        (rs1_addr == 5'd0) |-> (rs1_data == 32'h0))
        else $error("reg_file: x0 read back non-zero.");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_core -o sim_core

./obj_dir/sim_core > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    exit 0
fi
exit 1

// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;
    localparam logic [2:0] F3_CSRRC = 3'b011;

    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    localparam logic [31:0] INSTR_ECALL  = 32'h0000_0073;
    localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;
    localparam logic [31:0] INSTR_MRET   = 32'h3020_0073;

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    localparam logic [31:0] CAUSE_ECALL  = 32'd11;
    localparam logic [31:0] CAUSE_EBREAK = 32'd3;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_MUL, ALU_MULH, ALU_MULHU, ALU_DIVU, ALU_REMU, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_PC4, WB_CSR
    } wb_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } rv_instr_t;

endpackage

`default_nettype wire

// ==== sources.f ====
rv_pkg.sv
control.sv
imm_gen.sv
alu.sv
reg_file.sv
csr_unit.sv
core_top.sv
tb_core.sv

// ==== tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    localparam logic [31:0] MARKER = 32'h3fc;

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
    logic [3:0]  dmem_wstrb;
    logic        dmem_re;

    logic [31:0] imem [512];
    logic [7:0]  dmem [1024];
    logic        st_chk [512];
    logic [3:0]  st_strb [512];
    logic [31:0] st_data [512], st_mask [512], nx_exp [512];
    logic        nx_chk [512];
    logic [31:0] opnd [4];
    logic [31:0] ecall_addr, ebreak_addr, mret_addr, trap_ret, mt;
    logic [31:0] fetch_exp;
    logic [8:0]  cur;
    int          p, n_instr, r_off, errors, tests_done, phase_err_base;

    core_top #(.RESET_PC(32'h0), .MTVEC_RESET(32'h100)) uut (.*);

    always #5 clk = ~clk;

    assign cur        = imem_addr[10:2];
    assign imem_rdata = imem[cur];
    assign dmem_rdata = !dmem_re ? 32'h0 : // bus returns data only on a read.
                        {dmem[{dmem_addr[9:2], 2'd3}], dmem[{dmem_addr[9:2], 2'd2}],
                         dmem[{dmem_addr[9:2], 2'd1}], dmem[{dmem_addr[9:2], 2'd0}]};

    always @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (dmem_wstrb[i]) begin
                dmem[{dmem_addr[9:2], 2'(i)}] <= dmem_wdata[8*i +: 8];
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] enc_r(input int f7, rs2, rs1, f3, rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), rv_pkg::OP_R};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, rs1, f3, rd, input logic [6:0] op);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, rs2, rs1, f3);
        logic [11:0] v;
        v = 12'(imm);
        return {v[11:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:0], rv_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, rs2, rs1, f3);
        logic [12:0] v;
        v = 13'(imm);
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], rv_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input int imm20, rd, input logic [6:0] op);
        return {20'(imm20), 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, rd);
        logic [20:0] v;
        v = 21'(imm);
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), rv_pkg::OP_JAL};
    endfunction

    // k indexes the op table in arith_pair.
    function automatic logic [31:0] expect_alu(input int k, input logic [31:0] a, b);
        logic [63:0] pu, ps;
        pu = {32'h0, a} * {32'h0, b};
        ps = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        case (k)
            0:       return a + b;
            1:       return a - b;
            2:       return {31'h0, a < b};
            3:       return pu[31:0];
            4:       return ps[63:32];
            5:       return pu[63:32];
            6:       return (b == 0) ? 32'hffff_ffff : a / b;
            default: return (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic logic branch_taken(input int f3, input logic [31:0] a, b);
        case (f3)
            0:       return a == b;
            1:       return a != b;
            4:       return $signed(a) < $signed(b);
            6:       return a < b;
            default: return a >= b; // bgeu.
        endcase
    endfunction

    function automatic string phase_name(input logic [31:0] id);
        case (id)
            1:       return "arithmetic";
            2:       return "load and store lanes";
            3:       return "control flow";
            4:       return "traps";
            5:       return "csr updates";
            default: return "reset";
        endcase
    endfunction

    task automatic put(input logic [31:0] w);
        imem[p] = w;
        p++;
        n_instr++;
    endtask

    task automatic expect_store(input logic [3:0] strb, input logic [31:0] mask, data);
        st_chk[p]  = 1'b1;
        st_strb[p] = strb;
        st_mask[p] = mask;
        st_data[p] = data;
    endtask

    task automatic store_result(input int rs2, input logic [31:0] value);
        expect_store(4'hf, 32'hffff_ffff, value);
        put(enc_s(r_off, rs2, 1, 2));
        r_off += 4;
    endtask

    task automatic mark(input int id);
        put(enc_i(id, 0, 0, 31, rv_pkg::OP_IMM));
        put(enc_s(MARKER, 31, 0, 2));
    endtask

    task automatic arith_pair(input int pr);
        int f7s [8] = '{0, 32, 0, 1, 1, 1, 1, 1};
        int f3s [8] = '{0, 0, 3, 0, 1, 3, 5, 7};
        put(enc_i(8 * pr, 0, 2, 2, rv_pkg::OP_LOAD));
        put(enc_i(8 * pr + 4, 0, 2, 3, rv_pkg::OP_LOAD));
        for (int k = 0; k < 8; k++) begin
            put(enc_r(f7s[k], 3, 2, f3s[k], 4));
            store_result(4, expect_alu(k, opnd[2*pr], opnd[2*pr+1]));
        end
    endtask

    task automatic branch_case(input int f3, rs1, rs2, input logic [31:0] a, b);
        nx_chk[p] = 1'b1;
        nx_exp[p] = branch_taken(f3, a, b) ? 32'(p * 4 + 8) : 32'(p * 4 + 4);
        put(enc_b(8, rs2, rs1, f3));
        put(32'h13); // skipped when taken.
    endtask

    task automatic csr_step(input int f3, v);
        put(enc_i(v, 0, 0, 17, rv_pkg::OP_IMM));
        put(enc_i(12'h305, 17, f3, 16, rv_pkg::OP_SYSTEM));
        store_result(16, mt);
        case (f3)
            1:       mt = 32'(v);
            2:       mt = mt | 32'(v);
            default: mt = mt & ~32'(v);
        endcase
    endtask

    task automatic trap_case(input logic [31:0] instr, cause);
        logic [31:0] trap_pc;
        trap_pc = 32'(p * 4);
        nx_chk[p] = 1'b1;
        nx_exp[p] = 32'h100;
        put(instr);
        put(enc_i(12'h3f0, 0, 2, 9, rv_pkg::OP_LOAD));
        store_result(9, cause);
        put(enc_i(12'h3f4, 0, 2, 9, rv_pkg::OP_LOAD));
        store_result(9, trap_pc);
    endtask

    task automatic build_program();
        logic [31:0] pat;
        pat = 32'hf180_70e2; // byte and half signs differ per lane.
        {dmem[67], dmem[66], dmem[65], dmem[64]} = pat;
        put(enc_i(123, 0, 0, 0, rv_pkg::OP_IMM)); // write to x0 is dropped.
        put(enc_i(12'h200, 0, 0, 1, rv_pkg::OP_IMM));
        store_result(0, 32'h0);
        mark(6);
        put(enc_j((96 - p) * 4, 0)); // hop over the trap handler.
        p = 64;
        put(enc_i(12'h342, 0, 2, 7, rv_pkg::OP_SYSTEM));
        put(enc_s(12'h3f0, 7, 0, 2));
        put(enc_i(12'h341, 0, 2, 8, rv_pkg::OP_SYSTEM));
        put(enc_s(12'h3f4, 8, 0, 2));
        put(enc_i(4, 8, 0, 8, rv_pkg::OP_IMM));
        put(enc_i(12'h341, 8, 1, 0, rv_pkg::OP_SYSTEM));
        mret_addr = 32'(p * 4);
        put(rv_pkg::INSTR_MRET);
        p = 96;
        arith_pair(0);
        arith_pair(1);
        mark(1);
        put(enc_i(0, 0, 2, 5, rv_pkg::OP_LOAD));
        for (int off = 0; off < 4; off++) begin
            expect_store(4'b0001 << off, 32'hff << (8 * off), (opnd[0] & 32'hff) << (8 * off));
            put(enc_s(12'h300 + off, 5, 0, 0));
        end
        for (int off = 0; off < 4; off += 2) begin
            expect_store(4'b0011 << off, 32'hffff << (8 * off),
                         (opnd[0] & 32'hffff) << (8 * off));
            put(enc_s(12'h300 + off, 5, 0, 1));
        end
        for (int off = 0; off < 4; off++) begin
            put(enc_i(64 + off, 0, 0, 6, rv_pkg::OP_LOAD));
            store_result(6, {{24{pat[8*off+7]}}, pat[8*off +: 8]});
            put(enc_i(64 + off, 0, 4, 6, rv_pkg::OP_LOAD));
            store_result(6, {24'h0, pat[8*off +: 8]});
        end
        for (int off = 0; off < 4; off += 2) begin
            put(enc_i(64 + off, 0, 1, 6, rv_pkg::OP_LOAD));
            store_result(6, {{16{pat[8*off+15]}}, pat[8*off +: 16]});
            put(enc_i(64 + off, 0, 5, 6, rv_pkg::OP_LOAD));
            store_result(6, {16'h0, pat[8*off +: 16]});
        end
        mark(2);
        put(enc_i(5, 0, 0, 10, rv_pkg::OP_IMM));
        put(enc_i(-3, 0, 0, 11, rv_pkg::OP_IMM));
        put(enc_i(5, 0, 0, 12, rv_pkg::OP_IMM));
        branch_case(0, 10, 12, 5, 5);
        branch_case(0, 10, 11, 5, -3);
        branch_case(1, 10, 11, 5, -3);
        branch_case(1, 10, 12, 5, 5);
        branch_case(4, 11, 10, -3, 5);
        branch_case(4, 10, 11, 5, -3);
        branch_case(6, 10, 11, 5, -3);
        branch_case(6, 11, 10, -3, 5);
        branch_case(7, 11, 10, -3, 5);
        branch_case(7, 10, 11, 5, -3);
        nx_chk[p] = 1'b1;
        nx_exp[p] = 32'(p * 4 + 8);
        put(enc_j(8, 13));
        put(32'h13);
        store_result(13, 32'(p * 4 - 4));
        put(enc_u(0, 14, rv_pkg::OP_AUIPC));
        nx_chk[p] = 1'b1;
        nx_exp[p] = 32'(p * 4 + 8); // odd offset 13 lands on the word past the nop.
        put(enc_i(13, 14, 0, 15, rv_pkg::OP_JALR));
        put(32'h13);
        store_result(15, 32'(p * 4 - 4));
        mark(3);
        mt = 32'h100;
        csr_step(1, 12'h1c0);
        csr_step(2, 12'h003);
        csr_step(3, 12'h0c0);
        csr_step(1, 12'h100);
        mark(5);
        ecall_addr = 32'(p * 4);
        trap_case(rv_pkg::INSTR_ECALL, 32'd11);
        ebreak_addr = 32'(p * 4);
        trap_case(rv_pkg::INSTR_EBREAK, 32'd3);
        mark(4);
    endtask

    always @(posedge clk) begin
        if (!reset && (imem_addr == ecall_addr || imem_addr == ebreak_addr)) begin
            trap_ret <= imem_addr + 32'd4;
        end
    end

    always @(posedge clk) begin
        fetch_exp <= nx_exp[cur];
    end

    store_lanes: assert property (@(posedge clk) disable iff (reset)
        st_chk[cur] |-> (dmem_wstrb == st_strb[cur]
                         && (dmem_wdata & st_mask[cur]) == st_data[cur]))
        else begin
            errors++;
            $display("[FAIL] %0t: store at pc %h wrote %h strb %b, expected %h strb %b",
                     $time, $sampled(imem_addr), $sampled(dmem_wdata), $sampled(dmem_wstrb),
                     st_data[$sampled(cur)], st_strb[$sampled(cur)]);
        end

    next_fetch: assert property (@(posedge clk) disable iff (reset)
        nx_chk[cur] |=> (imem_addr == fetch_exp))
        else begin
            errors++;
            $display("[FAIL] %0t: fetch at %h, expected %h", $time, $sampled(imem_addr),
                     $sampled(fetch_exp));
        end

    return_fetch: assert property (@(posedge clk) disable iff (reset)
        (imem_addr == mret_addr) |=> (imem_addr == trap_ret))
        else begin
            errors++;
            $display("[FAIL] %0t: mret went to %h, expected %h", $time,
                     $sampled(imem_addr), $sampled(trap_ret));
        end

    reset_quiet: assert property (@(posedge clk)
        (reset || $fell(reset)) |-> (dmem_wstrb == 4'h0 && !dmem_re))
        else begin
            errors++;
            $display("[FAIL] %0t: memory strobe active around reset", $time);
        end

    reset_pc: assert property (@(posedge clk) $fell(reset) |-> (imem_addr == 32'h0))
        else begin
            errors++;
            $display("[FAIL] %0t: first fetch at %h, expected 0", $time, $sampled(imem_addr));
        end

    always @(negedge clk) begin
        if (!reset && dmem_wstrb != 4'h0 && dmem_addr == MARKER) begin
            tests_done++;
            $display("test %0d %s finished, %0d errors", tests_done,
                     phase_name(dmem_wdata), errors - phase_err_base);
            phase_err_base = errors;
            if (tests_done == 6) begin
                $display("tests %0d, errors %0d", tests_done, errors);
                if (errors == 0) begin
                    $display("Done: no errors");
                end else begin
                    $display("Done: errors found");
                end
                $finish;
            end
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        p = 0;
        n_instr = 0;
        r_off = 0;
        errors = 0;
        tests_done = 0;
        phase_err_base = 0;
        trap_ret = 32'h0;
        for (int i = 0; i < 512; i++) begin
            imem[i] = 32'h13;
            st_chk[i] = 1'b0;
            nx_chk[i] = 1'b0;
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = 8'(i ^ (i >> 8)); // differs across the whole address.
        end
        opnd[0] = xorshift(32'd97);
        opnd[1] = xorshift(opnd[0]);
        opnd[2] = xorshift(opnd[1]);
        opnd[3] = 32'h0; // zero divisor.
        for (int i = 0; i < 16; i++) begin
            dmem[i] = opnd[i / 4][8 * (i % 4) +: 8];
        end
        build_program();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        repeat (n_instr * 20 + 100) @(posedge clk);
        $display("timeout: the program did not reach its last phase marker");
        $display("tests %0d, errors %0d", tests_done, errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
